// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := thread_core_tb
FILELIST   := thread_core.f
OBJ_DIR    := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "TEST OK" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== include/core_defs.svh ====
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// datapath widths

// byte address width, instruction and data side
`define ADDR_SIZE 32

// operand and result width
`define DATA_SIZE 32

// inter-cpu message code width
`define CPU_MSG_SIZE 8

// thread layout

// header bytes placed in front of every thread entry point
`define THREAD_HEADER_SPACE 16

// dispatcher side

// number of threads the dispatcher can track at once
`define THREAD_SLOTS 4

// cycles from a sampled request to the done pulse being seen
// by the requester, keep at 2 or more
`define DISP_LATENCY 3

`endif

// ==== test/thread_core_tb.sv ====
`default_nettype none

`include "core_defs.svh"

module thread_core_tb
  import core_pkg::*;
  import msg_pkg::*;
();

  localparam int CNT_W       = $clog2(`THREAD_SLOTS + 1);
  localparam int SLOT_W      = $clog2(`THREAD_SLOTS);
  // request pulse edge to busy low
  localparam int DONE_GAP    = `DISP_LATENCY + 3;
  localparam int NOP_BUSY    = 3;
  localparam int MAX_CMDS    = 40;
  localparam int CYCLE_LIMIT = MAX_CMDS * (`DISP_LATENCY + 10);

  logic                  clk;
  logic                  rst;
  logic                  cmd_valid;
  core_cmd_t             cmd;
  logic [`ADDR_SIZE-1:0] base_addr;
  logic [`DATA_SIZE-1:0] base_addr_data;
  logic                  disp_enable;
  logic                  busy;
  thread_req_t           req;
  logic [CNT_W-1:0]      thread_count;
  logic                  overflow;

  integer seed = 32'h802373d4;
  int     errors = 0;
  int     n_cmds = 0;
  int     n_reqs = 0;
  int     cycles = 0;

  // model of the command in flight
  logic                  cmd_open;
  logic [3:0]            exp_code;
  logic                  exp_thread;
  logic [`ADDR_SIZE-1:0] exp_addr;
  logic [`DATA_SIZE-1:0] exp_data;
  int                    req_count;
  logic                  req_track;
  int                    since_req;
  logic                  nop_track;
  int                    nop_cnt;
  // disp_enable as the controller sees it
  logic                  en_d1;
  logic                  en_d2;

  // model thread table
  logic [`THREAD_SLOTS-1:0] m_valid;
  logic [`ADDR_SIZE-1:0]    m_hdr [`THREAD_SLOTS];
  logic                     m_overflow;
  logic [CNT_W-1:0]         m_count;

  // forked threads, reused for matching stops
  logic [31:0] known_src0 [$];
  logic [31:0] known_base [$];

  thread_core thread_core_inst (
    .clk            (clk),
    .rst            (rst),
    .cmd_valid      (cmd_valid),
    .cmd            (cmd),
    .base_addr      (base_addr),
    .base_addr_data (base_addr_data),
    .disp_enable    (disp_enable),
    .busy           (busy),
    .req            (req),
    .thread_count   (thread_count),
    .overflow       (overflow)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  // entry point rebased, header below it for a stop
  function automatic logic [`ADDR_SIZE-1:0] entry_addr(input logic [3:0] code,
      input logic [`DATA_SIZE-1:0] src0, input logic [`ADDR_SIZE-1:0] base);
    logic [`ADDR_SIZE-1:0] sum;
    sum = src0 + base;
    if (code == CMD_STOP) begin
      sum = sum - `THREAD_HEADER_SPACE;
    end
    return sum;
  endfunction

  // argument block, zero stays zero
  function automatic logic [`DATA_SIZE-1:0] arg_addr(input logic [3:0] code,
      input logic [`DATA_SIZE-1:0] src1, input logic [`DATA_SIZE-1:0] base);
    logic [`DATA_SIZE-1:0] sum;
    sum = src1 + base;
    if (code == CMD_STOP) begin
      sum = sum - `THREAD_HEADER_SPACE;
    end
    return (src1 == '0) ? '0 : sum;
  endfunction

  function automatic void mismatch(input string what);
    $display("Mismatch at time %0t: %s", $time, what);
    errors++;
  endfunction

  assign exp_thread = (exp_code == CMD_FORK) || (exp_code == CMD_STOP);

  // command and request tracking, sampled like the sequencer does
  always @(posedge clk) begin
    if (rst) begin
      cmd_open  <= 1'b0;
      req_track <= 1'b0;
      nop_track <= 1'b0;
      req_count <= 0;
      en_d1     <= 1'b0;
      en_d2     <= 1'b0;
    end else begin
      en_d1 <= disp_enable;
      en_d2 <= en_d1;
      if (cmd_open && !busy) begin
        cmd_open <= 1'b0;
      end
      if (nop_track) begin
        if (nop_cnt == NOP_BUSY + 1) begin
          nop_track <= 1'b0;
        end else begin
          nop_cnt <= nop_cnt + 1;
        end
      end
      if (req.msg != MSG_NONE) begin
        req_count <= req_count + 1;
        n_reqs++;
        req_track <= 1'b1;
        since_req <= 1;
      end else if (req_track) begin
        if (since_req == DONE_GAP) begin
          req_track <= 1'b0;
        end else begin
          since_req <= since_req + 1;
        end
      end
      // accepted only while idle
      if (cmd_valid && !busy) begin
        cmd_open  <= 1'b1;
        exp_code  <= cmd.word[31:28];
        exp_addr  <= entry_addr(cmd.word[31:28], cmd.src0, base_addr);
        exp_data  <= arg_addr(cmd.word[31:28], cmd.src1, base_addr_data);
        req_count <= 0;
        if (cmd.word[31:28] != CMD_FORK && cmd.word[31:28] != CMD_STOP) begin
          nop_track <= 1'b1;
          nop_cnt   <= 1;
        end
      end
    end
  end

  // table model, updated on the edge the dispatcher samples the request
  always @(posedge clk) begin
    logic              has_free;
    logic              has_hit;
    logic [SLOT_W-1:0] free_slot;
    logic [SLOT_W-1:0] hit_slot;
    has_free  = 1'b0;
    has_hit   = 1'b0;
    free_slot = '0;
    hit_slot  = '0;
    for (int i = `THREAD_SLOTS - 1; i >= 0; i--) begin
      if (!m_valid[i]) begin
        has_free  = 1'b1;
        free_slot = SLOT_W'(i);
      end
      if (m_valid[i] && m_hdr[i] == exp_addr) begin
        has_hit  = 1'b1;
        hit_slot = SLOT_W'(i);
      end
    end
    if (rst) begin
      m_valid    <= '0;
      m_overflow <= 1'b0;
    end else if (req.msg != MSG_NONE && exp_code == CMD_FORK) begin
      if (has_free) begin
        m_valid[free_slot] <= 1'b1;
        m_hdr[free_slot]   <= exp_addr - `THREAD_HEADER_SPACE;
      end else begin
        m_overflow <= 1'b1;
      end
    end else if (req.msg != MSG_NONE && exp_code == CMD_STOP && has_hit) begin
      m_valid[hit_slot] <= 1'b0;
    end
  end

  always_comb begin
    m_count = '0;
    for (int i = 0; i < `THREAD_SLOTS; i++) begin
      m_count = m_count + CNT_W'(m_valid[i]);
    end
  end

  // checks on the falling edge, all values settled
  fork_req_a: assert property (@(negedge clk) disable iff (rst)
    req.msg == CPU_R_FORK_THRD |->
      exp_code == CMD_FORK && req.addr == exp_addr && req.data == exp_data)
    else mismatch("fork request addr or data differs from the rebased operands");
  stop_req_a: assert property (@(negedge clk) disable iff (rst)
    req.msg == CPU_R_STOP_THRD |->
      exp_code == CMD_STOP && req.addr == exp_addr && req.data == exp_data)
    else mismatch("stop request addr or data differs from the header addresses");
  quiet_bus_a: assert property (@(negedge clk) disable iff (rst)
    req.msg == MSG_NONE |-> req.addr == '0 && req.data == '0)
    else mismatch("req addr or data nonzero without a message");
  req_allowed_a: assert property (@(negedge clk) disable iff (rst)
    req.msg != MSG_NONE |-> cmd_open && exp_thread && req_count == 0)
    else mismatch("req pulse for a nop, a second pulse or no command");
  req_total_a: assert property (@(negedge clk) disable iff (rst)
    cmd_open && !busy |-> req_count == (exp_thread ? 1 : 0))
    else mismatch("wrong number of req pulses for the finished command");
  done_hold_a: assert property (@(negedge clk) disable iff (rst)
    req_track && since_req < DONE_GAP |-> busy)
    else mismatch("busy fell early after the request");
  done_fall_a: assert property (@(negedge clk) disable iff (rst)
    req_track && since_req == DONE_GAP |-> !busy)
    else mismatch("busy still high after the dispatcher latency");
  nop_hold_a: assert property (@(negedge clk) disable iff (rst)
    nop_track && nop_cnt <= NOP_BUSY |-> busy)
    else mismatch("busy fell early for a nop");
  nop_fall_a: assert property (@(negedge clk) disable iff (rst)
    nop_track && nop_cnt == NOP_BUSY + 1 |-> !busy)
    else mismatch("busy held too long for a nop");
  offline_req_a: assert property (@(negedge clk) disable iff (rst)
    req.msg != MSG_NONE |-> en_d2)
    else mismatch("req sent while the dispatcher was offline");
  offline_busy_a: assert property (@(negedge clk) disable iff (rst)
    cmd_open && exp_thread && req_count == 0 |-> busy)
    else mismatch("busy fell before the request went out");
  count_a: assert property (@(negedge clk) disable iff (rst)
    thread_count == m_count)
    else mismatch("thread_count differs from the model table");
  overflow_a: assert property (@(negedge clk) disable iff (rst)
    overflow == m_overflow)
    else mismatch("overflow differs from the model table");

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: commands still running after %0d cycles", cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  // one command strobe once the core is idle
  task automatic drive_cmd(input logic [3:0] code, input logic [31:0] s0,
      input logic [31:0] s1, input logic [31:0] ba, input logic [31:0] bd);
    logic [31:0] low;
    low = $random(seed);
    @(negedge clk);
    while (busy) @(negedge clk);
    @(posedge clk);
    cmd_valid      <= 1'b1;
    cmd.word       <= {code, low[27:0]};
    cmd.src0       <= s0;
    cmd.src1       <= s1;
    base_addr      <= ba;
    base_addr_data <= bd;
    @(posedge clk);
    cmd_valid <= 1'b0;
    n_cmds++;
  endtask

  task automatic wait_idle();
    @(negedge clk);
    while (busy) @(negedge clk);
  endtask

  task automatic do_nop();
    drive_cmd(CMD_NOP, $random(seed), $random(seed), $random(seed), $random(seed));
    wait_idle();
  endtask

  // squeeze adds a stop strobe while the fork is still busy
  task automatic do_fork(input bit zero_arg, input bit squeeze);
    logic [31:0] s0;
    logic [31:0] s1;
    logic [31:0] ba;
    s0 = $random(seed);
    s1 = zero_arg ? 32'h0 : $random(seed);
    ba = $random(seed);
    known_src0.push_back(s0);
    known_base.push_back(ba);
    drive_cmd(CMD_FORK, s0, s1, ba, $random(seed));
    if (squeeze) begin
      @(posedge clk);
      cmd_valid <= 1'b1;
      cmd.word  <= {CMD_STOP, 28'h0};
      cmd.src0  <= $random(seed);
      cmd.src1  <= $random(seed);
      @(posedge clk);
      cmd_valid <= 1'b0;
    end
    wait_idle();
  endtask

  // negative idx stops an unknown thread, hold keeps the dispatcher off
  task automatic do_stop(input int idx, input bit zero_arg, input int hold);
    logic [31:0] s0;
    logic [31:0] ba;
    s0 = $random(seed);
    ba = $random(seed);
    if (idx >= 0) begin
      s0 = known_src0[idx];
      ba = known_base[idx];
    end
    drive_cmd(CMD_STOP, s0, zero_arg ? 32'h0 : $random(seed), ba, $random(seed));
    if (hold > 0) begin
      repeat (hold) @(posedge clk);
      disp_enable <= 1'b1;
    end
    wait_idle();
  endtask

  initial begin
    logic [31:0] pick;
    rst            = 1'b1;
    cmd_valid      = 1'b0;
    cmd            = '0;
    base_addr      = '0;
    base_addr_data = '0;
    disp_enable    = 1'b1;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    repeat (3) do_nop();
    // fill the table, one fork without argument block
    do_fork(1'b0, 1'b0);
    do_fork(1'b1, 1'b0);
    do_fork(1'b0, 1'b0);
    do_fork(1'b0, 1'b0);
    // table full here
    do_fork(1'b0, 1'b0);
    do_stop(0, 1'b0, 0);
    do_stop(-1, 1'b0, 0);
    do_stop(2, 1'b1, 0);
    // strobe while busy must be dropped
    do_fork(1'b0, 1'b1);
    // dispatcher offline before the stop arrives
    @(posedge clk);
    disp_enable <= 1'b0;
    repeat (2) @(posedge clk);
    do_stop(1, 1'b0, 8);
    for (int i = 0; i < 14; i++) begin
      pick = $random(seed);
      case (pick[1:0])
        2'd0:    do_nop();
        2'd1:    do_fork(pick[2], 1'b0);
        2'd2:    do_stop(int'(pick[7:4]) % known_src0.size(), pick[3], 0);
        default: do_stop(-1, pick[3], 0);
      endcase
    end
    repeat (4) @(posedge clk);
    $display("checks done: %0d errors, %0d commands, %0d requests", errors, n_cmds, n_reqs);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== thread_core.f ====
+incdir+include
verilog/core_pkg.sv
verilog/msg_pkg.sv
verilog/exec_sequencer.sv
verilog/thread_ctlr.sv
verilog/thread_dispatcher.sv
verilog/thread_core.sv
test/thread_core_tb.sv

// ==== verilog/core_pkg.sv ====
`default_nettype none

`include "core_defs.svh"

package core_pkg;

  // exec sequencer states
  typedef enum logic [1:0] {
    IDLE         = 2'd0,
    ALU_BEGIN    = 2'd1,
    FINISH_BEGIN = 2'd2
  } exec_state_t;

  // opcode in bits 31:28 of the command word
  typedef enum logic [3:0] {
    CMD_NOP  = 4'h0,
    CMD_FORK = 4'h1,
    CMD_STOP = 4'h2
  } cmd_code_t;

  // one decoded command with its operands
  typedef struct packed {
    logic [31:0]            word;
    logic [`DATA_SIZE-1:0]  src1;
    logic [`DATA_SIZE-1:0]  src0;
  } core_cmd_t;

  // pull the opcode out of a command
  function automatic cmd_code_t cmd_code_of(core_cmd_t c);
    return cmd_code_t'(c.word[31:28]);
  endfunction

endpackage

`default_nettype wire

// ==== verilog/exec_sequencer.sv ====
`default_nettype none

`include "core_defs.svh"

module exec_sequencer
  import core_pkg::*;
(
  input  logic        clk,
  input  logic        rst,

  // new command from decode
  input  logic        cmd_valid,
  input  core_cmd_t   cmd,

  // completion pulse from the thread controller
  input  logic        next_state,

  output exec_state_t state,
  output core_cmd_t   cur_cmd,
  output logic        busy
);

  // a command is only taken while nothing is in flight
  logic take_cmd;

  assign take_cmd = (state == IDLE) && cmd_valid;

  // state walk
  // idle -> alu_begin -> finish_begin -> idle
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: begin
          if (take_cmd) begin
            state <= ALU_BEGIN;
          end
        end
        ALU_BEGIN: begin
          // stays here until the unit doing the work says so
          if (next_state) begin
            state <= FINISH_BEGIN;
          end
        end
        FINISH_BEGIN: begin
          // single writeback cycle
          state <= IDLE;
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // command holding register
  // operands stay stable for the whole alu phase
  always_ff @(posedge clk) begin
    if (take_cmd) begin
      cur_cmd <= cmd;
    end
  end

  // back-pressure to decode
  assign busy = (state != IDLE);

endmodule

`default_nettype wire

// ==== verilog/msg_pkg.sv ====
`default_nettype none

`include "core_defs.svh"

package msg_pkg;

  // inter-cpu message codes
  // requests come from a core, done replies from the dispatcher
  typedef enum logic [`CPU_MSG_SIZE-1:0] {
    MSG_NONE        = 8'h00,
    CPU_R_FORK_THRD = 8'h01,
    CPU_R_STOP_THRD = 8'h02,
    CPU_R_FORK_DONE = 8'h81,
    CPU_R_STOP_DONE = 8'h82
  } cpu_msg_t;

  // request to the dispatcher
  // addr and data are zero while msg is MSG_NONE
  typedef struct packed {
    cpu_msg_t               msg;
    logic [`ADDR_SIZE-1:0]  addr;
    logic [`DATA_SIZE-1:0]  data;
  } thread_req_t;

  // done reply that belongs to a request code
  function automatic cpu_msg_t done_of(cpu_msg_t m);
    return (m == CPU_R_STOP_THRD) ? CPU_R_STOP_DONE : CPU_R_FORK_DONE;
  endfunction

endpackage

`default_nettype wire

// ==== verilog/thread_core.sv ====
`default_nettype none

`include "core_defs.svh"

module thread_core
  import core_pkg::*;
  import msg_pkg::*;
(
  input  logic                                clk,
  input  logic                                rst,

  // command side
  input  logic                                cmd_valid,
  input  core_cmd_t                           cmd,
  input  logic [`ADDR_SIZE-1:0]               base_addr,
  input  logic [`DATA_SIZE-1:0]               base_addr_data,

  // dispatcher enable level
  input  logic                                disp_enable,

  output logic                                busy,
  output thread_req_t                         req,
  output logic [$clog2(`THREAD_SLOTS+1)-1:0]  thread_count,
  output logic                                overflow
);

  exec_state_t state;
  core_cmd_t   cur_cmd;
  logic        next_state;
  logic        disp_online;
  cpu_msg_t    cpu_msg;

  // holds the command and walks the exec states
  exec_sequencer exec_sequencer_inst (
    .clk        (clk),
    .rst        (rst),
    .cmd_valid  (cmd_valid),
    .cmd        (cmd),
    .next_state (next_state),
    .state      (state),
    .cur_cmd    (cur_cmd),
    .busy       (busy)
  );

  // fork and stop requests, req is also a top output
  thread_ctlr thread_ctlr_inst (
    .clk            (clk),
    .rst            (rst),
    .state          (state),
    .cur_cmd        (cur_cmd),
    .base_addr      (base_addr),
    .base_addr_data (base_addr_data),
    .disp_online    (disp_online),
    .cpu_msg_in     (cpu_msg),
    .req            (req),
    .next_state     (next_state)
  );

  thread_dispatcher thread_dispatcher_inst (
    .clk          (clk),
    .rst          (rst),
    .disp_enable  (disp_enable),
    .req          (req),
    .disp_online  (disp_online),
    .cpu_msg_out  (cpu_msg),
    .thread_count (thread_count),
    .overflow     (overflow)
  );

endmodule

`default_nettype wire

// ==== verilog/thread_ctlr.sv ====
`default_nettype none

`include "core_defs.svh"

module thread_ctlr
  import core_pkg::*;
  import msg_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,

  // from the exec sequencer
  input  exec_state_t            state,
  input  core_cmd_t              cur_cmd,

  // relocation bases for code and argument blocks
  input  logic [`ADDR_SIZE-1:0]  base_addr,
  input  logic [`DATA_SIZE-1:0]  base_addr_data,

  // dispatcher status and replies
  input  logic                   disp_online,
  input  cpu_msg_t               cpu_msg_in,

  output thread_req_t            req,
  output logic                   next_state
);

  cmd_code_t             cmd_code;
  logic                  is_thread_cmd;
  logic                  is_stop;
  cpu_msg_t              req_code;
  cpu_msg_t              done_code;
  logic [`ADDR_SIZE-1:0] addr_adj;
  logic [`DATA_SIZE-1:0] data_adj;
  logic [`ADDR_SIZE-1:0] addr_calc;
  logic [`DATA_SIZE-1:0] data_calc;

  // request registers
  cpu_msg_t              msg_r;
  logic [`ADDR_SIZE-1:0] addr_r;
  logic [`DATA_SIZE-1:0] data_r;
  // request for the current command already went out
  logic                  signal_sent;

  assign cmd_code      = cmd_code_of(cur_cmd);
  assign is_stop       = (cmd_code == CMD_STOP);
  assign is_thread_cmd = (cmd_code == CMD_FORK) || is_stop;
  assign req_code      = is_stop ? CPU_R_STOP_THRD : CPU_R_FORK_THRD;
  assign done_code     = done_of(req_code);

  // stop points at the thread header, fork at the entry point
  assign addr_adj  = is_stop ? `ADDR_SIZE'(`THREAD_HEADER_SPACE) : '0;
  assign data_adj  = is_stop ? `DATA_SIZE'(`THREAD_HEADER_SPACE) : '0;
  assign addr_calc = cur_cmd.src0 + base_addr - addr_adj;
  // no argument block when src1 is zero
  assign data_calc = (cur_cmd.src1 == '0) ? '0
                   : cur_cmd.src1 + base_addr_data - data_adj;

  always_ff @(posedge clk) begin
    if (rst) begin
      msg_r       <= MSG_NONE;
      signal_sent <= 1'b0;
      next_state  <= 1'b0;
    end else begin
      // message and completion are single-cycle strobes
      msg_r      <= MSG_NONE;
      next_state <= 1'b0;
      // skip the cycle where next_state is already up,
      // the sequencer leaves alu_begin on that edge
      if (state == ALU_BEGIN && !next_state) begin
        if (is_thread_cmd) begin
          if (!signal_sent) begin
            // nothing goes out while the dispatcher is offline
            if (disp_online) begin
              addr_r      <= addr_calc;
              data_r      <= data_calc;
              msg_r       <= req_code;
              signal_sent <= 1'b1;
            end
          end else if (cpu_msg_in == done_code) begin
            signal_sent <= 1'b0;
            next_state  <= 1'b1;
          end
        end else begin
          // nop and unknown codes have no thread work
          next_state <= 1'b1;
        end
      end
    end
  end

  // bus is quiet unless a message is on it
  always_comb begin
    req.msg  = msg_r;
    req.addr = (msg_r == MSG_NONE) ? '0 : addr_r;
    req.data = (msg_r == MSG_NONE) ? '0 : data_r;
  end

endmodule

`default_nettype wire

// ==== verilog/thread_dispatcher.sv ====
`default_nettype none

`include "core_defs.svh"

module thread_dispatcher
  import msg_pkg::*;
(
  input  logic                                 clk,
  input  logic                                 rst,

  // external enable for the whole dispatcher
  input  logic                                 disp_enable,

  // fork and stop requests from the core
  input  thread_req_t                          req,

  output logic                                 disp_online,
  output cpu_msg_t                             cpu_msg_out,
  output logic [$clog2(`THREAD_SLOTS+1)-1:0]   thread_count,
  output logic                                 overflow
);

  localparam int SLOT_W  = $clog2(`THREAD_SLOTS);
  localparam int COUNT_W = $clog2(`THREAD_SLOTS + 1);
  localparam int DLY_W   = $clog2(`DISP_LATENCY + 1);
  // done is registered one edge before the requester samples it
  localparam logic [DLY_W-1:0] DLY_LOAD = DLY_W'(`DISP_LATENCY - 1);

  // thread table
  logic [`THREAD_SLOTS-1:0] slot_valid;
  logic [`ADDR_SIZE-1:0]    slot_hdr [`THREAD_SLOTS];

  // slot lookup
  logic                  has_free;
  logic [SLOT_W-1:0]     free_idx;
  logic                  has_match;
  logic [SLOT_W-1:0]     match_idx;
  logic [`ADDR_SIZE-1:0] fork_hdr;

  // service delay
  logic [DLY_W-1:0]      dly_cnt;
  cpu_msg_t              done_msg;

  // header sits just below the entry point
  assign fork_hdr = req.addr - `ADDR_SIZE'(`THREAD_HEADER_SPACE);

  // lowest free slot, first matching slot
  always_comb begin
    has_free  = 1'b0;
    free_idx  = '0;
    has_match = 1'b0;
    match_idx = '0;
    for (int i = 0; i < `THREAD_SLOTS; i++) begin
      if (!has_free && !slot_valid[i]) begin
        has_free = 1'b1;
        free_idx = SLOT_W'(i);
      end
      if (!has_match && slot_valid[i] && slot_hdr[i] == req.addr) begin
        has_match = 1'b1;
        match_idx = SLOT_W'(i);
      end
    end
  end

  // table update and overflow flag
  always_ff @(posedge clk) begin
    if (rst) begin
      slot_valid <= '0;
      overflow   <= 1'b0;
    end else begin
      if (req.msg == CPU_R_FORK_THRD) begin
        if (has_free) begin
          slot_valid[free_idx] <= 1'b1;
        end else begin
          // sticky until reset
          overflow <= 1'b1;
        end
      end else if (req.msg == CPU_R_STOP_THRD && has_match) begin
        // unknown thread is ignored
        slot_valid[match_idx] <= 1'b0;
      end
    end
  end

  // header addresses, written with the valid bit
  always_ff @(posedge clk) begin
    if (req.msg == CPU_R_FORK_THRD && has_free) begin
      slot_hdr[free_idx] <= fork_hdr;
    end
  end

  // countdown and done reply
  always_ff @(posedge clk) begin
    if (rst) begin
      dly_cnt     <= '0;
      cpu_msg_out <= MSG_NONE;
    end else begin
      cpu_msg_out <= MSG_NONE;
      if (req.msg == CPU_R_FORK_THRD || req.msg == CPU_R_STOP_THRD) begin
        dly_cnt  <= DLY_LOAD;
        done_msg <= done_of(req.msg);
      end else if (dly_cnt != '0) begin
        dly_cnt <= dly_cnt - 1'b1;
        if (dly_cnt == DLY_W'(1)) begin
          cpu_msg_out <= done_msg;
        end
      end
    end
  end

  // live thread count
  always_comb begin
    thread_count = '0;
    for (int i = 0; i < `THREAD_SLOTS; i++) begin
      thread_count = thread_count + COUNT_W'(slot_valid[i]);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      disp_online <= 1'b0;
    end else begin
      disp_online <= disp_enable;
    end
  end

endmodule

`default_nettype wire
